// File: hdl/audio_pkg.sv
// audio codec port definitions

package audio_pkg;

	////////////////////////////////////////
	// rates and word format
	////////////////////////////////////////

	// reference clock, 18.432 MHz
	localparam int REF_CLK = 18432000;
	// 48 kHz frame rate
	localparam int SAMPLE_RATE = 48000;
	// bits per sample
	localparam int SAMPLE_WIDTH = 16;
	// left and right
	localparam int CHANNEL_NUM = 2;

	////////////////////////////////////////
	// divider counts
	////////////////////////////////////////

	// ref cycles per bck half period, 6
	localparam int BCK_HALF = REF_CLK / (SAMPLE_RATE * SAMPLE_WIDTH * CHANNEL_NUM * 2);
	// ref cycles per lrck half period, 192 = 16 bck periods
	localparam int LRCK_HALF = REF_CLK / (SAMPLE_RATE * 2);
	// counter widths
	localparam int BCK_DIV_W = $clog2(BCK_HALF);
	localparam int LRCK_DIV_W = $clog2(LRCK_HALF);
	localparam int BIT_IDX_W = $clog2(SAMPLE_WIDTH);

	// bit position in a word, 0 is the msb
	typedef logic [BIT_IDX_W-1:0] bit_idx_t;
	// one signed audio sample
	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
	// stereo pair, left in the upper half
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

endpackage

// File: hdl/audio_timing_if.sv
// shared serial bit timing

`timescale 1ns/1ps

interface audio_timing_if;

	// high for the left channel
	logic lrck;
	// position of the current bit, 0 for the msb
	audio_pkg::bit_idx_t bit_sel;
	// strobe in the cycle that takes bck low
	logic bck_fall;
	// strobe in the cycle that takes lrck low
	logic frame_start;

	// clock generator side
	modport gen (
		output lrck,
		output bit_sel,
		output bck_fall,
		output frame_start
	);

	// serializer and deserializer side
	modport sink (
		input lrck,
		input bit_sel,
		input bck_fall,
		input frame_start
	);

endinterface

// File: hdl/audio_clock_gen.sv
// codec bit and frame clock generator

`timescale 1ns/1ps

module audio_clock_gen (
	input  logic                iCLK_18_4,
	input  logic                iRST_N,
	audio_timing_if.gen         tim,
	output logic                bck,
	output logic                lrck_out
);

	// divider counters
	logic [audio_pkg::BCK_DIV_W-1:0]  bck_div;
	logic [audio_pkg::LRCK_DIV_W-1:0] lrck_div;
	// toggle registers
	logic bck_q;
	logic lrck_q;
	// end of a half period
	logic bck_end;
	logic lrck_end;
	// decoded strobes
	logic bck_fall;
	logic frame_start;
	// bit position within the word
	audio_pkg::bit_idx_t bit_sel_q;

	////////////////////////////////////////
	// bck divider
	////////////////////////////////////////

	// last count of a bck half
	assign bck_end = (bck_div == audio_pkg::BCK_DIV_W'(audio_pkg::BCK_HALF - 1));

	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			bck_div <= '0;
			bck_q   <= 1'b0;
		end
		else if (bck_end)
		begin
			bck_div <= '0;
			bck_q   <= ~bck_q;
		end
		else
		begin
			bck_div <= bck_div + 1'b1;
		end
	end

	////////////////////////////////////////
	// lrck divider
	////////////////////////////////////////

	// 192 counts, lines up with every 16th bck fall
	assign lrck_end = (lrck_div == audio_pkg::LRCK_DIV_W'(audio_pkg::LRCK_HALF - 1));

	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			lrck_div <= '0;
			lrck_q   <= 1'b0;
		end
		else if (lrck_end)
		begin
			lrck_div <= '0;
			lrck_q   <= ~lrck_q;
		end
		else
		begin
			lrck_div <= lrck_div + 1'b1;
		end
	end

	// strobes decoded while the old level is still visible
	assign bck_fall    = bck_end & bck_q;
	assign frame_start = lrck_end & lrck_q;

	// bit index, wraps after 16 falls
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
			bit_sel_q <= '0;
		else if (bck_fall)
			bit_sel_q <= bit_sel_q + 1'b1;
	end

	// shared timing out
	assign tim.lrck        = lrck_q;
	assign tim.bit_sel     = bit_sel_q;
	assign tim.bck_fall    = bck_fall;
	assign tim.frame_start = frame_start;

	// codec pins
	assign bck      = bck_q;
	assign lrck_out = lrck_q;

endmodule

// File: hdl/dac_serializer.sv
// dac bit stream serializer

`timescale 1ns/1ps

module dac_serializer (
	input  logic                 iCLK_18_4,
	input  logic                 iRST_N,
	audio_timing_if.sink         tim,
	input  audio_pkg::sample_t   dac_left,
	input  audio_pkg::sample_t   dac_right,
	output logic                 dacdat
);

	// pair held for the whole frame
	audio_pkg::stereo_t pair_q;
	// cycle after a bck fall
	logic bck_fall_d;
	// msb first
	audio_pkg::bit_idx_t bit_pos;
	logic next_bit;

	// one consistent pair per frame
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
			pair_q <= '0;
		else if (tim.frame_start)
		begin
			pair_q.left  <= dac_left;
			pair_q.right <= dac_right;
		end
	end

	// bit 15 down to bit 0
	assign bit_pos = audio_pkg::bit_idx_t'(audio_pkg::SAMPLE_WIDTH - 1) - tim.bit_sel;

	// lrck high sends the left word
	assign next_bit = tim.lrck ? pair_q.left[bit_pos] : pair_q.right[bit_pos];

	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			bck_fall_d <= 1'b0;
			dacdat     <= 1'b0;
		end
		else
		begin
			bck_fall_d <= tim.bck_fall;
			// new index and pair are visible by now
			if (bck_fall_d)
				dacdat <= next_bit;
		end
	end

endmodule

// File: hdl/adc_deserializer.sv
// adc bit stream deserializer

`timescale 1ns/1ps

module adc_deserializer (
	input  logic                 iCLK_18_4,
	input  logic                 iRST_N,
	audio_timing_if.sink         tim,
	input  logic                 adcdat,
	output audio_pkg::stereo_t   adc_pair,
	output logic                 adc_valid
);

	// capture words, filled one bit per bck fall
	audio_pkg::sample_t cap_left;
	audio_pkg::sample_t cap_right;
	// position of the incoming bit
	audio_pkg::bit_idx_t bit_pos;
	// frame boundary, one cycle late
	logic frame_start_d;

	// msb arrives first
	assign bit_pos = audio_pkg::bit_idx_t'(audio_pkg::SAMPLE_WIDTH - 1) - tim.bit_sel;

	////////////////////////////////////////
	// capture
	////////////////////////////////////////

	// channel picked by the level of the ending bit
	always_ff @(posedge iCLK_18_4)
	begin
		if (tim.bck_fall)
		begin
			if (tim.lrck)
				cap_left[bit_pos] <= adcdat;
			else
				cap_right[bit_pos] <= adcdat;
		end
	end

	////////////////////////////////////////
	// publish
	////////////////////////////////////////

	// last left bit lands at frame_start
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
			frame_start_d <= 1'b0;
		else
			frame_start_d <= tim.frame_start;
	end

	// whole pair moves at once, outputs change only here
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			adc_pair  <= '0;
			adc_valid <= 1'b0;
		end
		else
		begin
			adc_valid <= frame_start_d;
			if (frame_start_d)
			begin
				adc_pair.left  <= cap_left;
				adc_pair.right <= cap_right;
			end
		end
	end

endmodule

// File: hdl/audio_dac_adc.sv
// serial audio codec port top

`timescale 1ns/1ps

module audio_dac_adc (
	input  logic                 iCLK_18_4,
	input  logic                 iRST_N,
	// samples toward the dac
	input  audio_pkg::sample_t   dac_left,
	input  audio_pkg::sample_t   dac_right,
	// samples from the adc
	output audio_pkg::sample_t   adc_left,
	output audio_pkg::sample_t   adc_right,
	output logic                 adc_valid,
	// codec pins
	output logic                 aud_bck,
	output logic                 aud_lrck,
	output logic                 aud_dacdat,
	input  logic                 aud_adcdat
);

	// bit timing shared by both serial blocks
	audio_timing_if tim ();

	// captured pair before the split
	audio_pkg::stereo_t adc_pair;

	////////////////////////////////////////
	// timing source
	////////////////////////////////////////

	audio_clock_gen u_clock_gen (
		.iCLK_18_4 (iCLK_18_4),
		.iRST_N    (iRST_N),
		.tim       (tim.gen),
		.bck       (aud_bck),
		.lrck_out  (aud_lrck)
	);

	// playback path
	dac_serializer u_dac (
		.iCLK_18_4 (iCLK_18_4),
		.iRST_N    (iRST_N),
		.tim       (tim.sink),
		.dac_left  (dac_left),
		.dac_right (dac_right),
		.dacdat    (aud_dacdat)
	);

	// record path
	adc_deserializer u_adc (
		.iCLK_18_4 (iCLK_18_4),
		.iRST_N    (iRST_N),
		.tim       (tim.sink),
		.adcdat    (aud_adcdat),
		.adc_pair  (adc_pair),
		.adc_valid (adc_valid)
	);

	// split the pair onto plain ports
	assign adc_left  = adc_pair.left;
	assign adc_right = adc_pair.right;

endmodule

// File: bench/audio_dac_adc_asserts.sv
// codec clock and strobe assertions

`timescale 1ns/1ps

module audio_dac_adc_asserts (
	input logic iCLK_18_4,
	input logic iRST_N,
	input logic aud_bck,
	input logic aud_lrck,
	input logic adc_valid
);

	// bck one cycle back
	logic bck_d;
	// cycles since the last bck change
	logic [3:0] bck_run;
	// first toggle after reset seen
	logic bck_seen;

	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			bck_d    <= 1'b0;
			bck_run  <= '0;
			bck_seen <= 1'b0;
		end
		else
		begin
			bck_d <= aud_bck;
			if (aud_bck != bck_d)
			begin
				bck_run  <= 4'd1;
				bck_seen <= 1'b1;
			end
			else if (bck_run != 4'd15)
				bck_run <= bck_run + 4'd1;
		end
	end

	////////////////////////////////////////
	// clock relations
	////////////////////////////////////////

	// each level of bck lasts exactly 6 cycles
	bck_toggle_at_six: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
		(bck_seen && (aud_bck != bck_d)) |-> (bck_run == 4'd6))
		else $error("aud_bck toggled after a run other than 6 cycles");

	bck_hold_under_six: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
		(bck_seen && (aud_bck == bck_d)) |-> (bck_run < 4'd6))
		else $error("aud_bck held its level longer than 6 cycles");

	// lrck moves together with a bck fall
	lrck_on_bck_fall: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
		$changed(aud_lrck) |-> $fell(aud_bck))
		else $error("aud_lrck changed outside a bck fall");

	////////////////////////////////////////
	// valid strobe
	////////////////////////////////////////

	valid_one_cycle: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
		adc_valid |=> !adc_valid)
		else $error("adc_valid stayed high for more than one cycle");

	valid_after_fall: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
		$fell(aud_lrck) |=> adc_valid)
		else $error("adc_valid missing one cycle after the lrck fall");

	valid_only_after_fall: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
		adc_valid |-> ($past(aud_lrck, 2) && !$past(aud_lrck)))
		else $error("adc_valid without a preceding lrck fall");

endmodule

bind audio_dac_adc audio_dac_adc_asserts u_asserts (
	.iCLK_18_4 (iCLK_18_4),
	.iRST_N    (iRST_N),
	.aud_bck   (aud_bck),
	.aud_lrck  (aud_lrck),
	.adc_valid (adc_valid)
);

// File: bench/audio_dac_adc_tb.sv
// codec port testbench

`timescale 1ns/1ps

module audio_dac_adc_tb;

	////////////////////////////////////////
	// model constants
	////////////////////////////////////////

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 5;
	// 18.432 MHz / 48 kHz, 16 bits per channel
	localparam int BCK_PERIOD   = 12;
	localparam int BCK_HIGH     = 6;
	localparam int LRCK_PERIOD  = 384;
	localparam int WORD_BITS    = 16;
	localparam int RUN_FRAMES   = 30;
	// 40 lrck periods plus reset
	localparam int TIMEOUT_CYCLES = 40 * LRCK_PERIOD + RESET_CYCLES;

	// dut ports
	logic iCLK_18_4;
	logic iRST_N;
	audio_pkg::sample_t dac_left;
	audio_pkg::sample_t dac_right;
	audio_pkg::sample_t adc_left;
	audio_pkg::sample_t adc_right;
	logic adc_valid;
	logic aud_bck;
	logic aud_lrck;
	logic aud_dacdat;
	logic aud_adcdat;

	// random source
	int seed = 32'h99c0c9ca;
	int rnd;
	logic adc_bit;
	// result counters
	int check_cnt = 0;
	int err_cnt = 0;
	// values of the cycle ending at the current edge, and the one before
	logic s_bck, s_lrck, s_dacdat, s_valid;
	audio_pkg::sample_t s_adc_left, s_adc_right;
	logic p_bck = 1'b0;
	logic p_lrck = 1'b0;
	audio_pkg::sample_t p_dac_left, p_dac_right;
	// cycle bookkeeping
	int rst_samples = 0;
	int cyc = 0;
	int last_rise = -1;
	int last_fall = -1;
	int rise_cnt = 0;
	logic fall_prev = 1'b0;
	// dac model, pair latched at the lrck fall
	logic have_pair = 1'b0;
	audio_pkg::sample_t exp_left, exp_right;
	audio_pkg::sample_t dac_word;
	int dac_cnt = 0;
	int words_checked = 0;
	// adc model, last 16 bits sent per channel
	audio_pkg::sample_t sent_left = '0;
	audio_pkg::sample_t sent_right = '0;
	audio_pkg::sample_t held_left = '0;
	audio_pkg::sample_t held_right = '0;
	int valid_cnt = 0;

	audio_dac_adc UUT (
		.iCLK_18_4  (iCLK_18_4),
		.iRST_N     (iRST_N),
		.dac_left   (dac_left),
		.dac_right  (dac_right),
		.adc_left   (adc_left),
		.adc_right  (adc_right),
		.adc_valid  (adc_valid),
		.aud_bck    (aud_bck),
		.aud_lrck   (aud_lrck),
		.aud_dacdat (aud_dacdat),
		.aud_adcdat (aud_adcdat)
	);

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic compare_sample(input string name, input audio_pkg::sample_t got,
		input audio_pkg::sample_t expected);
		check_cnt++;
		if (got !== expected)
		begin
			err_cnt++;
			$display("MISMATCH %0t ns %s got %0d expected %0d", $time, name, got, expected);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic expected);
		check_cnt++;
		if (got !== expected)
		begin
			err_cnt++;
			$display("MISMATCH %0t ns %s got %b expected %b", $time, name, got, expected);
		end
	endtask

	task automatic compare_count(input string name, input int got, input int expected);
		check_cnt++;
		if (got != expected)
		begin
			err_cnt++;
			$display("MISMATCH %0t ns %s got %0d expected %0d", $time, name, got, expected);
		end
	endtask

	// all codec pins and outputs idle
	task automatic check_reset_state();
		compare_bit("aud_bck", s_bck, 1'b0);
		compare_bit("aud_lrck", s_lrck, 1'b0);
		compare_bit("aud_dacdat", s_dacdat, 1'b0);
		compare_bit("adc_valid", s_valid, 1'b0);
		compare_sample("adc_left", s_adc_left, '0);
		compare_sample("adc_right", s_adc_right, '0);
	endtask

	task automatic print_counts();
		$display("checks: %0d  errors: %0d", check_cnt, err_cnt);
	endtask

	// 40 ns reference clock
	initial
	begin
		iCLK_18_4 = 1'b0;
		forever #(CLK_PERIOD / 2) iCLK_18_4 = ~iCLK_18_4;
	end

	////////////////////////////////////////
	// codec side model and stimulus
	////////////////////////////////////////

	always @(posedge iCLK_18_4)
	begin
		s_bck       = aud_bck;
		s_lrck      = aud_lrck;
		s_dacdat    = aud_dacdat;
		s_valid     = adc_valid;
		s_adc_left  = adc_left;
		s_adc_right = adc_right;
		if (!iRST_N)
		begin
			// first sample may still show power-up values
			if (rst_samples > 0)
				check_reset_state();
			rst_samples++;
		end
		else
		begin
			cyc++;
			if (cyc <= RESET_CYCLES)
				check_reset_state();
			// valid one cycle after each lrck fall and nowhere else
			compare_bit("adc_valid", s_valid, fall_prev);
			fall_prev = p_lrck && !s_lrck;
			if (s_bck && !p_bck)
			begin
				if (last_rise >= 0)
					compare_count("aud_bck period", cyc - last_rise, BCK_PERIOD);
				last_rise = cyc;
				rise_cnt++;
				// next adc bit, captured by the dut at the bck fall
				rnd = $random(seed);
				adc_bit = rnd[0];
				aud_adcdat <= adc_bit;
				if (s_lrck)
					sent_left = {sent_left[14:0], adc_bit};
				else
					sent_right = {sent_right[14:0], adc_bit};
				// codec side dac capture, msb first
				if (have_pair)
				begin
					dac_word = {dac_word[14:0], s_dacdat};
					dac_cnt++;
					if (dac_cnt == WORD_BITS)
					begin
						if (s_lrck)
							compare_sample("dac word left", dac_word, exp_left);
						else
							compare_sample("dac word right", dac_word, exp_right);
						dac_cnt = 0;
						words_checked++;
					end
				end
			end
			if (!s_bck && p_bck && last_rise >= 0)
				compare_count("aud_bck high time", cyc - last_rise, BCK_HIGH);
			if (s_lrck != p_lrck)
			begin
				compare_count("aud_bck rises per lrck half", rise_cnt, WORD_BITS);
				rise_cnt = 0;
				dac_cnt  = 0;
			end
			if (p_lrck && !s_lrck)
			begin
				if (last_fall >= 0)
					compare_count("aud_lrck period", cyc - last_fall, LRCK_PERIOD);
				last_fall = cyc;
				// inputs as seen at the edge that moved lrck
				exp_left  = p_dac_left;
				exp_right = p_dac_right;
				have_pair = 1'b1;
			end
			// adc pair only moves with valid
			if (s_valid)
			begin
				valid_cnt++;
				// first pulse carries a partial right word
				if (valid_cnt > 1)
				begin
					compare_sample("adc_left", s_adc_left, sent_left);
					compare_sample("adc_right", s_adc_right, sent_right);
				end
				held_left  = s_adc_left;
				held_right = s_adc_right;
			end
			else
			begin
				compare_sample("adc_left held", s_adc_left, held_left);
				compare_sample("adc_right held", s_adc_right, held_right);
			end
			// dac inputs change at random points in the frame
			rnd = $random(seed);
			if (rnd[4:0] == 5'd0)
				dac_left <= rnd[31:16];
			if (rnd[9:5] == 5'd0)
				dac_right <= rnd[25:10];
		end
		p_bck       = s_bck;
		p_lrck      = s_lrck;
		p_dac_left  = dac_left;
		p_dac_right = dac_right;
	end

	////////////////////////////////////////
	// run control
	////////////////////////////////////////

	initial
	begin
		iRST_N     = 1'b0;
		dac_left   = '0;
		dac_right  = '0;
		aud_adcdat = 1'b0;
		repeat (RESET_CYCLES) @(posedge iCLK_18_4);
		iRST_N <= 1'b1;
		wait (valid_cnt >= RUN_FRAMES);
		@(posedge iCLK_18_4);
		if (words_checked < 2 * (RUN_FRAMES - 1))
		begin
			err_cnt++;
			$display("ERROR: only %0d dac words were compared", words_checked);
		end
		print_counts();
		if (err_cnt == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		err_cnt++;
		$display("ERROR: timeout, adc_valid seen only %0d of %0d times", valid_cnt, RUN_FRAMES);
		print_counts();
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: audio_dac_adc.f
hdl/audio_pkg.sv
hdl/audio_timing_if.sv
hdl/audio_clock_gen.sv
hdl/dac_serializer.sv
hdl/adc_deserializer.sv
hdl/audio_dac_adc.sv
bench/audio_dac_adc_asserts.sv
bench/audio_dac_adc_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the codec port testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module audio_dac_adc_tb \
	-f audio_dac_adc.f \
	-Mdir obj_dir -o audio_dac_adc_sim

status=0
output=$(./obj_dir/audio_dac_adc_sim) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx "Simulation completed successfully"
then
	echo "run_sim: PASS"
	exit 0
else
	echo "run_sim: FAIL"
	exit 1
fi
